// File: rtl/mmu_bus_switch.sv
`timescale 1ns/1ps

module mmu_bus_switch (
    input  logic [1:0]      priv,
    input  logic [63:0]     satp,

    input  mmu_pkg::tl_a_t  virt_a,
    input  logic            virt_a_valid,
    output logic            virt_a_ready,
    output mmu_pkg::tl_d_t  virt_d,
    output logic            virt_d_valid,
    input  logic            virt_d_ready,

    output mmu_pkg::tl_a_t  phy_a,
    output logic            phy_a_valid,
    input  logic            phy_a_ready,
    input  mmu_pkg::tl_d_t  phy_d,
    input  logic            phy_d_valid,
    output logic            phy_d_ready,

    input  mmu_pkg::tl_a_t  xl_a,
    input  logic            xl_a_valid,
    input  logic            xl_consume,
    input  mmu_pkg::tl_d_t  hold_d,
    input  logic            hold_d_valid,
    output logic            paging
);

    // Translation only in S mode with a non-bare satp
    assign paging = (priv == mmu_pkg::PRIV_S) &&
                    (satp[mmu_pkg::SATP_MODE_MSB:mmu_pkg::SATP_MODE_LSB] != '0);

    // A channel
    assign phy_a        = paging ? xl_a : virt_a;
    assign phy_a_valid  = paging ? xl_a_valid : virt_a_valid;
    assign virt_a_ready = paging ? xl_consume : phy_a_ready;

    // D channel, walker always sinks physical responses
    assign virt_d       = paging ? hold_d : phy_d;
    assign virt_d_valid = paging ? hold_d_valid : phy_d_valid;
    assign phy_d_ready  = paging ? 1'b1 : virt_d_ready;

    // Mode flips only while no translated beat is pending on either side
    a_paging_quiet: assert property (
        @(paging) (xl_a_valid !== 1'b1) && (hold_d_valid !== 1'b1)
    ) else $error("paging changed with a translated beat pending");

endmodule

// File: rtl/mmu_pkg.sv
package mmu_pkg;

    // A channel beat, master to slave
    typedef struct packed {
        logic [2:0]  opcode;
        logic [2:0]  param;
        logic [2:0]  size;      // log2 of byte count
        logic [3:0]  source;
        logic [63:0] address;
        logic [7:0]  mask;
        logic [63:0] data;
        logic        corrupt;
    } tl_a_t;

    // D channel beat, slave to master
    typedef struct packed {
        logic [2:0]  opcode;
        logic [1:0]  param;
        logic [2:0]  size;
        logic [3:0]  source;
        logic [5:0]  sink;
        logic        denied;
        logic [63:0] data;
        logic        corrupt;
    } tl_d_t;

    // Page table entry flag positions
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;

    // PPN field inside an entry
    localparam int PTE_PPN_LSB = 10;
    localparam int PTE_PPN_MSB = 53;

    localparam int PPN_BITS = 44;
    localparam int VPN_BITS = 27;

    // Sv39 geometry
    localparam int PAGE_OFFSET_BITS = 12;
    localparam int VPN_INDEX_BITS   = 9;
    localparam int LEVELS           = 3;   // Root table is level 0 internally

    localparam logic [1:0] PRIV_S = 2'd1;

    // satp.MODE
    localparam int SATP_MODE_MSB = 63;
    localparam int SATP_MODE_LSB = 60;

    localparam logic [2:0] TL_GET        = 3'd4;
    localparam logic [2:0] PTE_SIZE_LOG2 = 3'd3;   // 8 byte entries

endpackage

// File: rtl/mmu_resp_hold.sv
`timescale 1ns/1ps

module mmu_resp_hold (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            resp_expect,
    input  mmu_pkg::tl_d_t  phy_d,
    input  logic            phy_d_valid,
    input  logic            virt_d_ready,
    output mmu_pkg::tl_d_t  hold_d,
    output logic            hold_d_valid,
    output logic            resp_done
);

    logic capture;

    // Only the response of the translated access, one beat deep
    assign capture = resp_expect && phy_d_valid && !hold_d_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_d_valid <= 1'b0;
            resp_done    <= 1'b0;
        end else begin
            resp_done <= hold_d_valid && virt_d_ready;   // Walker may go idle next
            if (capture) begin
                hold_d_valid <= 1'b1;
            end else if (virt_d_ready) begin
                hold_d_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            hold_d <= phy_d;
        end
    end

    // Physical slave answers once per translated access
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n) hold_d_valid |-> !phy_d_valid
    ) else $error("physical response arrived while a beat is held");

endmodule

// File: rtl/mmu_top.sv
`timescale 1ns/1ps

module mmu_top #(
    parameter logic [3:0] WALK_SOURCE = 4'hf
) (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic [1:0]                    priv,
    input  logic [63:0]                   satp,

    // Virtual side
    input  mmu_pkg::tl_a_t                virt_a,
    input  logic                          virt_a_valid,
    output logic                          virt_a_ready,
    output mmu_pkg::tl_d_t                virt_d,
    output logic                          virt_d_valid,
    input  logic                          virt_d_ready,

    // Physical side
    output mmu_pkg::tl_a_t                phy_a,
    output logic                          phy_a_valid,
    input  logic                          phy_a_ready,
    input  mmu_pkg::tl_d_t                phy_d,
    input  logic                          phy_d_valid,
    output logic                          phy_d_ready,

    // External TLB
    output logic [mmu_pkg::VPN_BITS-1:0]  tlb_addr,
    input  logic [mmu_pkg::PPN_BITS-1:0]  tlb_rdata,
    input  logic                          tlb_hit,
    output logic [mmu_pkg::PPN_BITS-1:0]  tlb_wdata,
    output logic                          tlb_update,

    output logic                          page_fault,
    output logic [63:0]                   tval
);

    logic           paging;
    mmu_pkg::tl_a_t xl_a;           // Translated or page table request
    logic           xl_a_valid;
    logic           xl_consume;
    mmu_pkg::tl_d_t hold_d;
    logic           hold_d_valid;
    logic           resp_expect;
    logic           resp_done;

    mmu_bus_switch u_switch (
        .priv         (priv),
        .satp         (satp),
        .virt_a       (virt_a),
        .virt_a_valid (virt_a_valid),
        .virt_a_ready (virt_a_ready),
        .virt_d       (virt_d),
        .virt_d_valid (virt_d_valid),
        .virt_d_ready (virt_d_ready),
        .phy_a        (phy_a),
        .phy_a_valid  (phy_a_valid),
        .phy_a_ready  (phy_a_ready),
        .phy_d        (phy_d),
        .phy_d_valid  (phy_d_valid),
        .phy_d_ready  (phy_d_ready),
        .xl_a         (xl_a),
        .xl_a_valid   (xl_a_valid),
        .xl_consume   (xl_consume),
        .hold_d       (hold_d),
        .hold_d_valid (hold_d_valid),
        .paging       (paging)
    );

    mmu_walker #(
        .WALK_SOURCE (WALK_SOURCE)
    ) u_walker (
        .clk          (clk),
        .rst_n        (rst_n),
        .paging       (paging),
        .satp         (satp),
        .virt_a       (virt_a),
        .virt_a_valid (virt_a_valid),
        .phy_a_ready  (phy_a_ready),
        .phy_d        (phy_d),
        .phy_d_valid  (phy_d_valid),
        .tlb_rdata    (tlb_rdata),
        .tlb_hit      (tlb_hit),
        .resp_done    (resp_done),
        .xl_a         (xl_a),
        .xl_a_valid   (xl_a_valid),
        .xl_consume   (xl_consume),
        .resp_expect  (resp_expect),
        .tlb_addr     (tlb_addr),
        .tlb_wdata    (tlb_wdata),
        .tlb_update   (tlb_update),
        .page_fault   (page_fault),
        .tval         (tval)
    );

    mmu_resp_hold u_resp_hold (
        .clk          (clk),
        .rst_n        (rst_n),
        .resp_expect  (resp_expect),
        .phy_d        (phy_d),
        .phy_d_valid  (phy_d_valid),
        .virt_d_ready (virt_d_ready),
        .hold_d       (hold_d),
        .hold_d_valid (hold_d_valid),
        .resp_done    (resp_done)
    );

endmodule

// File: rtl/mmu_walker.sv
`timescale 1ns/1ps

module mmu_walker #(
    parameter logic [3:0] WALK_SOURCE = 4'hf
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          paging,
    input  logic [63:0]                   satp,
    input  mmu_pkg::tl_a_t                virt_a,
    input  logic                          virt_a_valid,
    input  logic                          phy_a_ready,
    input  mmu_pkg::tl_d_t                phy_d,
    input  logic                          phy_d_valid,
    input  logic [mmu_pkg::PPN_BITS-1:0]  tlb_rdata,
    input  logic                          tlb_hit,
    input  logic                          resp_done,
    output mmu_pkg::tl_a_t                xl_a,
    output logic                          xl_a_valid,
    output logic                          xl_consume,
    output logic                          resp_expect,
    output logic [mmu_pkg::VPN_BITS-1:0]  tlb_addr,
    output logic [mmu_pkg::PPN_BITS-1:0]  tlb_wdata,
    output logic                          tlb_update,
    output logic                          page_fault,
    output logic [63:0]                   tval
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_REQ0, S_DAT0,
        S_REQ1, S_DAT1,
        S_REQ2, S_DAT2,
        S_FWD,
        S_WAIT,
        S_FAULT
    } state_t;

    state_t                        state;
    mmu_pkg::tl_a_t                req_q;      // Original virtual request
    logic [63:0]                   pte_q;
    logic [1:0]                    lvl;
    logic [mmu_pkg::PPN_BITS-1:0]  pte_ppn;
    logic                          pte_leaf;
    logic                          pte_ptr;
    logic                          pte_bad;
    logic [63:0]                   keep_mask;
    logic [63:0]                   leaf_pa;
    logic                          start;

    // Get of one entry: table PPN, then VPN index of this level, then 8 byte slot
    function automatic mmu_pkg::tl_a_t pte_read(
        input logic [mmu_pkg::PPN_BITS-1:0] ppn,
        input logic [63:0]                  va,
        input logic [1:0]                   level
    );
        mmu_pkg::tl_a_t                      a;
        logic [mmu_pkg::VPN_INDEX_BITS-1:0]  idx;
        idx = va[mmu_pkg::PAGE_OFFSET_BITS +
                 mmu_pkg::VPN_INDEX_BITS * (mmu_pkg::LEVELS - 1 - level)
                 +: mmu_pkg::VPN_INDEX_BITS];
        a         = '0;
        a.opcode  = mmu_pkg::TL_GET;
        a.size    = mmu_pkg::PTE_SIZE_LOG2;
        a.source  = WALK_SOURCE;
        a.mask    = '1;
        a.address = 64'({ppn, idx, {mmu_pkg::PTE_SIZE_LOG2{1'b0}}});
        return a;
    endfunction

    assign start = (state == S_IDLE) && paging && virt_a_valid;

    // Level of the entry sitting in pte_q
    always_comb begin
        case (state)
            S_DAT1:  lvl = 2'd1;
            S_DAT2:  lvl = 2'd2;
            default: lvl = 2'd0;
        endcase
    end

    assign pte_ppn  = pte_q[mmu_pkg::PTE_PPN_MSB:mmu_pkg::PTE_PPN_LSB];
    assign pte_leaf = pte_q[mmu_pkg::PTE_V] &&
                      (pte_q[mmu_pkg::PTE_R] ||
                       (pte_q[mmu_pkg::PTE_X] && !pte_q[mmu_pkg::PTE_W]));
    assign pte_ptr  = pte_q[mmu_pkg::PTE_V] && !pte_q[mmu_pkg::PTE_R] &&
                      !pte_q[mmu_pkg::PTE_W] && !pte_q[mmu_pkg::PTE_X];
    // Pointer at the last level has nowhere to go
    assign pte_bad  = !pte_leaf && (!pte_ptr || (lvl == mmu_pkg::LEVELS - 1));

    // Superpage keeps the untranslated VPN slices of the virtual address
    assign keep_mask = (64'd1 << (mmu_pkg::PAGE_OFFSET_BITS +
                        mmu_pkg::VPN_INDEX_BITS * (mmu_pkg::LEVELS - 1 - lvl))) - 64'd1;
    assign leaf_pa   = (64'({pte_ppn, {mmu_pkg::PAGE_OFFSET_BITS{1'b0}}}) & ~keep_mask) |
                       (req_q.address & keep_mask);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            xl_a_valid <= 1'b0;
            tlb_update <= 1'b0;
        end else begin
            tlb_update <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        xl_a_valid <= 1'b1;
                        state      <= tlb_hit ? S_FWD : S_REQ0;
                    end
                end
                S_REQ0, S_REQ1, S_REQ2: begin
                    if (phy_a_ready) begin
                        xl_a_valid <= 1'b0;
                    end
                    if (phy_d_valid) begin
                        case (state)
                            S_REQ0:  state <= S_DAT0;
                            S_REQ1:  state <= S_DAT1;
                            default: state <= S_DAT2;
                        endcase
                    end
                end
                S_DAT0, S_DAT1, S_DAT2: begin
                    if (pte_bad) begin
                        state <= S_FAULT;
                    end else if (pte_leaf) begin
                        xl_a_valid <= 1'b1;
                        tlb_update <= 1'b1;   // Goes out with the first forward cycle
                        state      <= S_FWD;
                    end else begin
                        xl_a_valid <= 1'b1;
                        state      <= (state == S_DAT0) ? S_REQ1 : S_REQ2;
                    end
                end
                S_FWD: begin
                    if (phy_a_ready) begin
                        xl_a_valid <= 1'b0;
                        state      <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (resp_done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;   // S_FAULT lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (start) begin
                    req_q <= virt_a;
                    if (tlb_hit) begin
                        xl_a         <= virt_a;
                        xl_a.address <= 64'({tlb_rdata,
                                             virt_a.address[mmu_pkg::PAGE_OFFSET_BITS-1:0]});
                    end else begin
                        xl_a <= pte_read(satp[mmu_pkg::PPN_BITS-1:0], virt_a.address, 2'd0);
                    end
                end
            end
            S_REQ0, S_REQ1, S_REQ2: begin
                if (phy_d_valid) begin
                    pte_q <= phy_d.data;
                end
            end
            S_DAT0, S_DAT1, S_DAT2: begin
                if (pte_leaf) begin
                    xl_a         <= req_q;
                    xl_a.address <= leaf_pa;
                    tlb_wdata    <= leaf_pa[mmu_pkg::PAGE_OFFSET_BITS +: mmu_pkg::PPN_BITS];
                end else if (pte_ptr) begin
                    xl_a <= pte_read(pte_ppn, req_q.address, lvl + 2'd1);
                end
            end
            default: ;
        endcase
    end

    assign xl_consume  = (state == S_FWD && phy_a_ready) || (state == S_FAULT);
    assign resp_expect = (state == S_FWD) || (state == S_WAIT);  // Response may race the A beat
    assign page_fault  = (state == S_FAULT);
    assign tval        = page_fault ? req_q.address : 64'd0;

    assign tlb_addr = (state == S_IDLE) ?
                      virt_a.address[mmu_pkg::PAGE_OFFSET_BITS +: mmu_pkg::VPN_BITS] :
                      req_q.address[mmu_pkg::PAGE_OFFSET_BITS +: mmu_pkg::VPN_BITS];

    a_fault_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) page_fault |=> !page_fault
    ) else $error("page_fault held longer than one cycle");

    a_update_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) tlb_update |=> !tlb_update
    ) else $error("tlb_update held longer than one cycle");

    // Outstanding beat must stay put until the physical slave takes it
    a_xl_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        xl_a_valid && !phy_a_ready |=> xl_a_valid && $stable(xl_a)
    ) else $error("translated A beat dropped or changed before ready");

endmodule

// File: tb.f
+incdir+verif
rtl/mmu_pkg.sv
rtl/mmu_bus_switch.sv
rtl/mmu_walker.sv
rtl/mmu_resp_hold.sv
rtl/mmu_top.sv
verif/tb_mmu.sv

// File: verif/mmu_ref_model.svh
// Page table image keyed by physical byte address
logic [63:0] pt_mem [logic [63:0]];
logic [63:0] va_list [0:NVA-1];     // Virtual pages that have a built path
logic [63:0] exp_reads [$];         // Page table read addresses of the last walk
logic [63:0] exp_pa;
bit          exp_fault;

// Table base plus the 9 bit VPN slice of this level times 8
function automatic logic [63:0] pte_addr(input logic [43:0] tbl, input logic [63:0] va,
                                         input int l);
    return {8'd0, tbl, 12'd0} + (((va >> (12 + 9 * (2 - l))) & 64'h1ff) << 3);
endfunction

// Last entry of a path, leaf or malformed
function automatic logic [63:0] end_entry(input int kind, input int l);
    logic [3:0]  fl;
    logic [43:0] ppn;
    ppn = 44'({$random(seed), $random(seed)});
    case (kind)
        0:       fl = 4'b0011;                  // R
        1:       fl = 4'b0111;                  // RW
        2:       fl = 4'b1001;                  // Execute only
        3:       fl = 4'b1111;
        4:       fl = 4'b0100 | {3'b0, ppn[0]}; // W without R
        5:       fl = 4'b1100 | {3'b0, ppn[0]}; // WX without R
        6:       fl = {ppn[3:1], 1'b0};         // Not valid
        default: fl = (l == 2) ? 4'b0001 : 4'b1011;
    endcase
    return {10'd0, ppn, 6'd0, fl};
endfunction

function automatic void build_image();
    logic [63:0] va;
    logic [63:0] addr;
    logic [43:0] tbl;
    logic [43:0] next_ppn;
    int          t;
    next_ppn = ROOT_PPN + 44'd1;
    for (int i = 0; i < NVA; i++) begin
        va         = {25'd0, 27'($random(seed)), 12'd0};
        va_list[i] = va;
        t          = ($random(seed) & 32'h7fff) % 3;    // Level where the path ends
        tbl        = ROOT_PPN;
        for (int l = 0; l < 3; l++) begin
            addr = pte_addr(tbl, va, l);
            if (pt_mem.exists(addr)) begin
                // Shared prefix with an earlier path
                if (pt_mem[addr][3:0] != 4'b0001 || l == 2) break;
                tbl = pt_mem[addr][53:10];
            end else if (l == t) begin
                pt_mem[addr] = end_entry($random(seed) & 7, l);
                break;
            end else begin
                pt_mem[addr] = {10'd0, next_ppn, 10'b0000000001};
                tbl          = next_ppn;
                next_ppn     = next_ppn + 44'd1;
            end
        end
    end
endfunction

// Sv39 translation of one address over the image
function automatic void walk(input logic [63:0] va);
    logic [43:0] tbl;
    logic [63:0] addr;
    logic [63:0] pte;
    logic [63:0] keep;
    exp_reads.delete();
    exp_fault = 1'b1;
    tbl       = ROOT_PPN;
    for (int l = 0; l < 3; l++) begin
        addr = pte_addr(tbl, va, l);
        exp_reads.push_back(addr);
        pte = pt_mem.exists(addr) ? pt_mem[addr] : 64'd0;
        if (pte[0] && (pte[1] || (pte[3] && !pte[2]))) begin
            keep      = (64'd1 << (9 * (2 - l) + 12)) - 64'd1;
            exp_pa    = ({8'd0, pte[53:10], 12'd0} & ~keep) | (va & keep);
            exp_fault = 1'b0;
            return;
        end
        if (!(pte[0] && pte[3:1] == 3'b000)) return;
        tbl = pte[53:10];   // Pointer, or fault after the last level
    end
endfunction

// File: verif/tb_mmu.sv
`timescale 1ns/1ps

module tb_mmu;

    localparam int          NVA      = 24;
    localparam int          N_BYP    = 12;    // Per bypass flavour
    localparam int          N_PAGE   = 48;
    localparam int          LIMIT    = (2 * N_BYP + N_PAGE) * 64;
    localparam logic [43:0] ROOT_PPN = 44'h100;
    localparam logic [63:0] PATTERN  = 64'h5a5a_c3c3_0f0f_9696;

    logic           clk;
    logic           rst_n;
    logic [1:0]     priv;
    logic [63:0]    satp;
    mmu_pkg::tl_a_t virt_a, phy_a;
    mmu_pkg::tl_d_t virt_d, phy_d;
    logic           virt_a_valid, virt_a_ready, virt_d_valid, virt_d_ready;
    logic           phy_a_valid, phy_a_ready, phy_d_valid, phy_d_ready;
    logic [26:0]    tlb_addr;
    logic [43:0]    tlb_rdata, tlb_wdata;
    logic           tlb_hit, tlb_update, page_fault;
    logic [63:0]    tval;

    integer         seed = 34;
    int             errors, cycles, consumed, updates, faults, tlb_gen;
    bit             force_miss, d_active;
    mmu_pkg::tl_a_t a_log [$];
    mmu_pkg::tl_d_t d_log [$];
    mmu_pkg::tl_d_t rsp_q [$];     // Physical responses not yet sent
    logic [43:0]    tlb_tab [logic [26:0]];
    logic [63:0]    cur_va;

    `include "mmu_ref_model.svh"

    mmu_top #(.WALK_SOURCE(4'd15)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare(input string name, input logic [149:0] got,
                           input logic [149:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout after %0d cycles, a transaction never completed", cycles);
            $display("test failed");
            $finish;
        end
    end

    // Bus monitor and physical memory
    always @(posedge clk) begin
        mmu_pkg::tl_d_t r;
        r = '0;
        if (phy_a_valid && phy_a_ready) begin
            a_log.push_back(phy_a);
            r.opcode = 3'd1;                              // AccessAckData
            r.size   = phy_a.size;
            r.source = phy_a.source;
            if (phy_a.source == 4'd15)
                r.data = pt_mem.exists(phy_a.address) ? pt_mem[phy_a.address] : 64'd0;
            else
                r.data = phy_a.address ^ PATTERN;
            rsp_q.push_back(r);
        end
        if (phy_d_valid && phy_d_ready) d_active = 1'b0;
        if (virt_d_valid && virt_d_ready) d_log.push_back(virt_d);
        if (virt_a_valid && virt_a_ready) consumed++;
        if (page_fault) begin
            faults++;
            compare("tval", tval, cur_va);
        end
        if (tlb_update) begin
            updates++;
            compare("tlb_wdata", tlb_wdata, exp_pa[55:12]);
            compare("phy_a_valid with tlb_update", phy_a_valid, 1'b1);
            tlb_tab[tlb_addr] = tlb_wdata;
            tlb_gen++;
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            phy_a_ready = ($random(seed) & 3) != 0;
            if (($random(seed) & 3) == 0) virt_d_ready = !virt_d_ready;   // Stretches
            if (!d_active && rsp_q.size() > 0 && ($random(seed) & 1)) begin
                phy_d       = rsp_q.pop_front();
                phy_d_valid = 1'b1;
                d_active    = 1'b1;
            end else if (!d_active) begin
                phy_d_valid = 1'b0;
            end
        end
    end

    // External TLB
    always @(tlb_addr or force_miss or tlb_gen) begin
        tlb_hit   = !force_miss && !$isunknown(tlb_addr) && tlb_tab.exists(tlb_addr);
        tlb_rdata = tlb_hit ? tlb_tab[tlb_addr] : 44'd0;
    end

    // One virtual request, started and finished on falling edges
    task automatic run_txn(input bit paged, input logic [63:0] va);
        mmu_pkg::tl_a_t req;
        mmu_pkg::tl_a_t exp_a;
        mmu_pkg::tl_d_t exp_d;
        int             c0, u0, f0, n_rd;
        bit             hit;
        req         = '0;
        req.opcode  = 3'($random(seed)) & 3'd4;   // Get or PutFullData
        req.size    = 3'd3;
        req.source  = 4'(($random(seed) & 32'h7fff) % 15);
        req.address = va;
        req.mask    = 8'hff;
        req.data    = {$random(seed), $random(seed)};
        if (a_log.size() != 0 || d_log.size() != 0) begin
            errors++;
            $display("Unexpected bus beats left over before the request at %0t", $time);
        end
        cur_va    = va;
        exp_pa    = va;
        exp_fault = 1'b0;
        exp_reads.delete();
        if (paged) walk(va);
        hit = paged && !exp_fault && !force_miss && tlb_tab.exists(va[38:12]);
        c0  = consumed;
        u0  = updates;
        f0  = faults;
        virt_a       = req;
        virt_a_valid = 1'b1;
        do @(negedge clk); while (consumed == c0);
        // A translated request stays offered while its response is pending
        if (!paged || exp_fault) virt_a_valid = 1'b0;
        if (exp_fault) repeat (6) @(negedge clk);
        else while (d_log.size() == 0) @(negedge clk);
        virt_a_valid = 1'b0;
        compare("virt_a consume count", consumed - c0, 1);
        n_rd = hit ? 0 : exp_reads.size();
        compare("phy_a beat count", a_log.size(), n_rd + !exp_fault);
        for (int i = 0; i < n_rd && i < a_log.size(); i++) begin
            exp_a         = '0;
            exp_a.opcode  = 3'd4;
            exp_a.size    = 3'd3;
            exp_a.source  = 4'd15;
            exp_a.mask    = 8'hff;
            exp_a.address = exp_reads[i];
            compare("phy_a page table read", a_log[i], exp_a);
        end
        if (!exp_fault && a_log.size() == n_rd + 1) begin
            exp_a         = req;
            exp_a.address = exp_pa;
            compare("phy_a request", a_log[n_rd], exp_a);
            compare("virt_d data", d_log[0].data, exp_pa ^ PATTERN);
            exp_d         = '0;
            exp_d.opcode  = 3'd1;
            exp_d.size    = req.size;
            exp_d.source  = req.source;
            exp_d.data    = exp_pa ^ PATTERN;
            compare("virt_d beat", d_log[0], exp_d);
        end
        compare("virt_d beat count", d_log.size(), !exp_fault);
        compare("tlb_update count", updates - u0, paged && !hit && !exp_fault);
        compare("page_fault count", faults - f0, exp_fault);
        a_log.delete();
        d_log.delete();
    endtask

    initial begin
        rst_n        = 1'b0;
        priv         = 2'd3;
        satp         = {4'd8, 16'd0, ROOT_PPN};
        virt_a       = '0;
        virt_a_valid = 1'b0;
        virt_d_ready = 1'b1;
        phy_a_ready  = 1'b0;
        phy_d        = '0;
        phy_d_valid  = 1'b0;
        tlb_hit      = 1'b0;
        tlb_rdata    = '0;
        force_miss   = 1'b0;
        d_active     = 1'b0;
        build_image();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Machine mode ignores satp
        repeat (N_BYP) run_txn(1'b0, {$random(seed), $random(seed)});
        priv       = 2'd1;
        satp[63:60] = 4'd0;
        repeat (N_BYP) run_txn(1'b0, {$random(seed), $random(seed)});
        repeat (4) @(negedge clk);
        satp[63:60] = 4'd8;
        for (int n = 0; n < N_PAGE; n++) begin
            force_miss = ($random(seed) & 3) == 0;
            run_txn(1'b1, va_list[($random(seed) & 32'h7fff) % NVA] | 64'($random(seed) & 'hfff));
        end
        repeat (8) @(negedge clk);
        if (a_log.size() != 0 || d_log.size() != 0) begin
            errors++;
            $display("Extra bus beats appeared after the last transaction");
        end
        $display("Errors: %0d in %0d transactions", errors, 2 * N_BYP + N_PAGE);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
